//--- project.f
logic/accel_pkg.sv
logic/simple_fifo.sv
logic/accel_rd_dma.sv
logic/pattern_matcher.sv
logic/ip_match.sv
logic/accel_wrap.sv
logic/packet_mem.sv
logic/accel_top.sv
verification/clk_gen.sv
verification/tb_accel_top.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module tb_accel_top -f project.f -o sim_tb
	out="$$(./obj_dir/sim_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir

//--- verification/tb_accel_top.sv
`timescale 1ns/1ps

module tb_accel_top import accel_pkg::*; ();

  typedef enum logic [2:0] {op_write, op_read, op_poll, op_mem, op_rule} op_t;

  typedef struct {
    op_t         op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] expected;
    logic [31:0] mask;
    string       label;
  } step_t;

  localparam int cycles_per_step = 200;
  localparam int clk_period_ns   = 8;
  localparam int poll_limit      = 100;
  localparam int stall_limit     = 20;

  logic                       clk;
  logic                       rst;
  logic                       io_en;
  logic                       io_wen;
  logic [io_data_width/8-1:0] io_strb;
  logic [io_addr_width-1:0]   io_addr;
  logic [io_data_width-1:0]   io_wr_data;
  logic [io_data_width-1:0]   io_rd_data;
  logic                       io_rd_valid;
  logic                       pmem_wr_en;
  logic [pmem_addr_width-1:0] pmem_wr_addr;
  logic [31:0]                pmem_wr_data;
  logic                       rule_wr_en;
  logic [rule_addr_width-1:0] rule_wr_addr;
  logic [rule_id_width-1:0]   rule_wr_data;

  step_t       steps [$];
  logic [31:0] lcg_state = 32'hdcc7;
  logic [31:0] pmem_model [256];
  logic [7:0]  rule_model [256];
  bit          steps_ready;

  clk_gen #(.period_ns(clk_period_ns), .reset_cycles(16)) clk_gen_i (.clk(clk), .rst(rst));

  accel_top accel_top_i (
    .clk(clk), .rst(rst),
    .io_en(io_en), .io_wen(io_wen), .io_strb(io_strb), .io_addr(io_addr),
    .io_wr_data(io_wr_data), .io_rd_data(io_rd_data), .io_rd_valid(io_rd_valid),
    .pmem_wr_en(pmem_wr_en), .pmem_wr_addr(pmem_wr_addr), .pmem_wr_data(pmem_wr_data),
    .rule_wr_en(rule_wr_en), .rule_wr_addr(rule_wr_addr), .rule_wr_data(rule_wr_data)
  );

  function automatic logic [31:0] rand_word();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] swap_bytes(input logic [31:0] w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  // First nonzero rule wins and bytes shift in at the low end
  function automatic result_t model_packet(input logic [7:0] waddr, input int len,
                                           input logic [63:0] pre);
    result_t    r;
    logic [7:0] w;
    logic [7:0] b;
    r.hit     = 1'b0;
    r.rule_id = '0;
    r.state   = pre;
    for (int i = 0; i < len; i++) begin
      w       = waddr + 8'(i / 4);
      b       = pmem_model[w][8*(i%4) +: 8];
      r.state = {r.state[55:0], b};
      if (!r.hit && rule_model[b] != 8'd0) begin
        r.hit     = 1'b1;
        r.rule_id = rule_model[b];
      end
    end
    return r;
  endfunction

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      report_failure($sformatf("FAILED at %0t ns: %s is 0x%08h, expected 0x%08h",
                               $time, name, actual, expected));
    end
  endtask

  task automatic add_step(input op_t op, input logic [31:0] addr, input logic [31:0] data,
                          input logic [31:0] expected, input logic [31:0] mask,
                          input string label);
    step_t s;
    s.op       = op;
    s.addr     = addr;
    s.data     = data;
    s.expected = expected;
    s.mask     = mask;
    s.label    = label;
    steps.push_back(s);
  endtask

  task automatic add_write(input logic [io_addr_width-1:0] addr, input logic [31:0] data);
    add_step(op_write, 32'(addr), data, '0, '0, "");
  endtask

  task automatic add_read(input string label, input logic [io_addr_width-1:0] addr,
                          input logic [31:0] expected, input logic [31:0] mask);
    add_step(op_read, 32'(addr), '0, expected, mask, label);
  endtask

  task automatic start_packet(input logic [7:0] waddr, input int len, input logic [63:0] pre,
                              input logic [7:0] slot);
    add_write(reg_len, 32'(len));
    add_write(reg_addr, {24'd0, waddr});
    add_write(reg_pre_lo, pre[31:0]);
    add_write(reg_pre_hi, pre[63:32]);
    add_write(reg_slot, {24'd0, slot});
    add_write(reg_ctrl, 32'h1);
  endtask

  task automatic expect_packet(input logic [7:0] waddr, input int len, input logic [63:0] pre,
                               input logic [7:0] slot);
    result_t r;
    r = model_packet(waddr, len, pre);
    add_step(op_poll, 32'(reg_ctrl), '0, 32'h1, 32'h1, "reg_ctrl");
    add_read("reg_ctrl", reg_ctrl, {30'd0, r.hit, 1'b1}, 32'h3);
    add_read("reg_rule", reg_rule, {24'd0, r.rule_id}, 32'hff);
    add_read("reg_pre_lo", reg_pre_lo, r.state[31:0], '1);
    add_read("reg_pre_hi", reg_pre_hi, r.state[63:32], '1);
    add_read("reg_slot", reg_slot, {23'd0, 1'b1, slot}, 32'h1ff);
  endtask

  task automatic build_steps();
    logic [31:0] r;
    logic [31:0] word;
    logic [63:0] pre;
    logic [7:0]  q_addr [3];
    int          q_len [3];
    logic [63:0] q_pre [3];
    logic [31:0] listed_ip;
    for (int i = 0; i < 256; i++) begin
      r = rand_word();
      rule_model[i] = (r[7:5] == 3'd0) ? (r[15:8] | 8'h01) : 8'h00;
    end
    for (int i = 0; i < 256; i++) begin
      pmem_model[i] = rand_word();
    end
    // Byte 6 of the single packet always hits
    rule_model[pmem_model[8'h11][23:16]] = 8'h5a;
    // No-match packet uses only bytes whose rule ID is zero
    for (int w = 8'h40; w < 8'h43; w++) begin
      for (int k = 0; k < 4; k++) begin
        do begin
          r = rand_word();
        end while (rule_model[r[7:0]] != 8'd0);
        word[8*k +: 8] = r[7:0];
      end
      pmem_model[w] = word;
    end
    for (int i = 0; i < 256; i++) begin
      add_step(op_rule, 32'(i), {24'd0, rule_model[i]}, '0, '0, "");
    end
    for (int i = 0; i < 256; i++) begin
      add_step(op_mem, 32'(i), pmem_model[i], '0, '0, "");
    end

    // Register readback
    add_write(reg_len, 32'd13);
    add_read("reg_len", reg_len, 32'd13, 32'h3ff);
    add_write(reg_addr, 32'h10);
    add_read("reg_addr", reg_addr, 32'h10, 32'hff);
    add_write(reg_port, 32'h1234abcd);
    add_read("reg_port", reg_port, 32'h1234abcd, '1);
    add_write(reg_ip, 32'h0a0b0c0d);
    add_read("reg_ip", reg_ip, 32'h0a0b0c0d, '1);

    // Single packet of 13 bytes
    pre = {rand_word(), rand_word()};
    start_packet(8'h10, 13, pre, 8'ha5);
    expect_packet(8'h10, 13, pre, 8'ha5);
    add_read("reg_dma_stat", reg_dma_stat, 32'h101, 32'h10101);
    add_write(reg_ctrl, 32'h2);

    // Three starts back to back and drained in order
    q_addr = '{8'h20, 8'h28, 8'h30};
    q_len  = '{7, 16, 5};
    for (int k = 0; k < 3; k++) begin
      q_pre[k] = {rand_word(), rand_word()};
      start_packet(q_addr[k], q_len[k], q_pre[k], 8'(48 + k));
    end
    for (int k = 0; k < 3; k++) begin
      expect_packet(q_addr[k], q_len[k], q_pre[k], 8'(48 + k));
      add_write(reg_ctrl, 32'h2);
    end
    add_read("reg_ctrl", reg_ctrl, 32'h0, 32'h1);

    // No match
    pre = {rand_word(), rand_word()};
    start_packet(8'h40, 9, pre, 8'h5c);
    expect_packet(8'h40, 9, pre, 8'h5c);
    add_write(reg_ctrl, 32'h2);

    // Blocklist lookups with each read right after its write
    listed_ip = swap_bytes(blocklist[2]);
    add_write(reg_ip, listed_ip);
    add_read("reg_ip_stat", reg_ip_stat, 32'h1, 32'h1);
    add_write(reg_ip, 32'h04030201);
    add_read("reg_ip_stat", reg_ip_stat, 32'h0, 32'h1);

    // A long packet keeps the DMA busy while 17 more starts arrive
    add_read("reg_dma_stat", reg_dma_stat, 32'h0, 32'h10000);
    add_write(reg_len, 32'd1020);
    add_write(reg_addr, 32'h0);
    add_write(reg_ctrl, 32'h1);
    for (int k = 0; k < 17; k++) begin
      add_write(reg_ctrl, 32'h1);
    end
    add_read("reg_dma_stat", reg_dma_stat, 32'h10000, 32'h10000);
  endtask

  // Held until the next step drives the bus
  task automatic bus_write(input logic [io_addr_width-1:0] addr, input logic [31:0] data);
    @(posedge clk);
    io_en      <= 1'b1;
    io_wen     <= 1'b1;
    io_strb    <= 4'hf;
    io_addr    <= addr;
    io_wr_data <= data;
    pmem_wr_en <= 1'b0;
    rule_wr_en <= 1'b0;
  endtask

  task automatic bus_read(input logic [io_addr_width-1:0] addr, output logic [31:0] data);
    int waited;
    @(posedge clk);
    io_en      <= 1'b1;
    io_wen     <= 1'b0;
    io_addr    <= addr;
    pmem_wr_en <= 1'b0;
    rule_wr_en <= 1'b0;
    @(negedge clk);
    check_value("io_rd_valid", {31'd0, io_rd_valid}, 32'd0);
    @(posedge clk);
    io_en <= 1'b0;
    @(negedge clk);
    if (addr == reg_ip_stat) begin
      waited = 0;
      while (!io_rd_valid) begin
        waited++;
        if (waited > stall_limit) report_failure("stalled read of reg_ip_stat never completed");
        @(negedge clk);
      end
    end else begin
      check_value("io_rd_valid", {31'd0, io_rd_valid}, 32'd1);
    end
    data = io_rd_data;
  endtask

  task automatic apply_step(input step_t s);
    logic [31:0] data;
    int          tries;
    case (s.op)
      op_write: bus_write(s.addr[io_addr_width-1:0], s.data);
      op_read: begin
        bus_read(s.addr[io_addr_width-1:0], data);
        check_value(s.label, data & s.mask, s.expected);
      end
      op_poll: begin
        tries = 0;
        do begin
          if (tries == poll_limit) report_failure("result never became available in reg_ctrl");
          bus_read(s.addr[io_addr_width-1:0], data);
          tries++;
        end while ((data & s.mask) != s.expected);
      end
      op_mem: begin
        @(posedge clk);
        io_en        <= 1'b0;
        rule_wr_en   <= 1'b0;
        pmem_wr_en   <= 1'b1;
        pmem_wr_addr <= s.addr[pmem_addr_width-1:0];
        pmem_wr_data <= s.data;
      end
      default: begin
        @(posedge clk);
        io_en        <= 1'b0;
        pmem_wr_en   <= 1'b0;
        rule_wr_en   <= 1'b1;
        rule_wr_addr <= s.addr[rule_addr_width-1:0];
        rule_wr_data <= s.data[rule_id_width-1:0];
      end
    endcase
  endtask

  initial begin
    io_en        = 1'b0;
    io_wen       = 1'b0;
    io_strb      = '0;
    io_addr      = '0;
    io_wr_data   = '0;
    pmem_wr_en   = 1'b0;
    pmem_wr_addr = '0;
    pmem_wr_data = '0;
    rule_wr_en   = 1'b0;
    rule_wr_addr = '0;
    rule_wr_data = '0;
    build_steps();
    steps_ready = 1'b1;
    wait (rst == 1'b0);
    for (int i = 0; i < steps.size(); i++) begin
      apply_step(steps[i]);
    end
    @(posedge clk);
    io_en      <= 1'b0;
    pmem_wr_en <= 1'b0;
    rule_wr_en <= 1'b0;
    @(posedge clk);
    $display("Finished with no errors");
    $finish;
  end

  // Budget scales with the number of steps
  initial begin
    wait (steps_ready);
    #(steps.size() * cycles_per_step * clk_period_ns);
    report_failure("watchdog timeout, the step sequence did not finish in time");
  end

endmodule

//--- verification/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
  parameter int period_ns    = 8,
  parameter int reset_cycles = 16
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  // Released on a rising edge, as a synchronous reset
  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

//--- logic/accel_top.sv
`timescale 1ns/1ps

module accel_top import accel_pkg::*; (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       io_en,
  input  logic                       io_wen,
  input  logic [io_data_width/8-1:0] io_strb,
  input  logic [io_addr_width-1:0]   io_addr,
  input  logic [io_data_width-1:0]   io_wr_data,
  output logic [io_data_width-1:0]   io_rd_data,
  output logic                       io_rd_valid,
  input  logic                       pmem_wr_en,
  input  logic [pmem_addr_width-1:0] pmem_wr_addr,
  input  logic [31:0]                pmem_wr_data,
  input  logic                       rule_wr_en,
  input  logic [rule_addr_width-1:0] rule_wr_addr,
  input  logic [rule_id_width-1:0]   rule_wr_data
);

  logic                       mem_rd_en;
  logic [pmem_addr_width-1:0] mem_rd_addr;
  logic [31:0]                mem_rd_data;

  packet_mem packet_mem_i (
    .clk(clk),
    .wr_en(pmem_wr_en), .wr_addr(pmem_wr_addr), .wr_data(pmem_wr_data),
    .rd_en(mem_rd_en), .rd_addr(mem_rd_addr), .rd_data(mem_rd_data)
  );

  accel_wrap accel_wrap_i (
    .clk(clk), .rst(rst),
    .io_en(io_en), .io_wen(io_wen), .io_strb(io_strb), .io_addr(io_addr),
    .io_wr_data(io_wr_data), .io_rd_data(io_rd_data), .io_rd_valid(io_rd_valid),
    .rule_wr_en(rule_wr_en), .rule_wr_addr(rule_wr_addr), .rule_wr_data(rule_wr_data),
    .mem_rd_en(mem_rd_en), .mem_rd_addr(mem_rd_addr), .mem_rd_data(mem_rd_data)
  );

endmodule

//--- logic/packet_mem.sv
`timescale 1ns/1ps

module packet_mem import accel_pkg::*; (
  input  logic                       clk,
  input  logic                       wr_en,
  input  logic [pmem_addr_width-1:0] wr_addr,
  input  logic [31:0]                wr_data,
  input  logic                       rd_en,
  input  logic [pmem_addr_width-1:0] rd_addr,
  output logic [31:0]                rd_data
);

  logic [31:0] mem [2**pmem_addr_width];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read data shows up the cycle after rd_en
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

//--- logic/accel_wrap.sv
`timescale 1ns/1ps

module accel_wrap import accel_pkg::*; (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       io_en,
  input  logic                       io_wen,
  input  logic [io_data_width/8-1:0] io_strb,
  input  logic [io_addr_width-1:0]   io_addr,
  input  logic [io_data_width-1:0]   io_wr_data,
  output logic [io_data_width-1:0]   io_rd_data,
  output logic                       io_rd_valid,
  input  logic                       rule_wr_en,
  input  logic [rule_addr_width-1:0] rule_wr_addr,
  input  logic [rule_id_width-1:0]   rule_wr_data,
  output logic                       mem_rd_en,
  output logic [pmem_addr_width-1:0] mem_rd_addr,
  input  logic [31:0]                mem_rd_data
);

  logic [len_width-1:0]       cmd_len;
  logic [pmem_addr_width-1:0] cmd_addr;
  logic [31:0]                cmd_port;
  logic [63:0]                cmd_pre;
  logic [7:0]                 cmd_slot;
  logic [31:0]                ip_reg;
  logic                       ip_valid_q;
  logic                       wr;
  logic                       rd;
  logic                       start_wr;
  logic                       release_wr;
  logic                       ip_stat_rd;
  logic                       stall_start;
  logic                       stall;
  logic                       dma_done;
  logic                       dma_err;
  logic [io_data_width-1:0]   rd_mux;

  desc_t       desc_in;
  desc_t       desc_head;
  logic        desc_in_ready;
  logic        desc_valid;
  logic        desc_ready;
  logic [63:0] pre_head;
  logic        pre_valid;
  logic        pre_ready;
  logic [7:0]  slot_head;
  logic        slot_valid;
  result_t     res_in;
  logic        res_in_valid;
  logic        res_in_ready;
  result_t     res_head;
  logic        res_valid;
  logic [31:0] beat_data;
  logic [2:0]  beat_bytes;
  logic        beat_last;
  logic        beat_valid;
  logic        beat_ready;
  logic        ip_hit;
  logic        ip_done;

  assign wr         = io_en && io_wen;
  assign rd         = io_en && !io_wen;
  assign start_wr   = wr && (io_addr == reg_ctrl) && io_strb[0] && io_wr_data[0];
  assign release_wr = wr && (io_addr == reg_ctrl) && io_strb[0] && io_wr_data[1];
  assign ip_stat_rd = rd && (io_addr == reg_ip_stat);
  // Lookup still running, or just kicked off by the previous write
  assign stall_start = ip_stat_rd && (!ip_done || ip_valid_q);

  always_ff @(posedge clk) begin
    if (wr) begin
      case (io_addr)
        reg_len:    cmd_len  <= io_wr_data[len_width-1:0];
        reg_addr:   cmd_addr <= io_wr_data[pmem_addr_width-1:0];
        reg_port: begin
          if (io_strb[1] && io_strb[0]) cmd_port[15:0] <= io_wr_data[15:0];
          if (io_strb[3] && io_strb[2]) cmd_port[31:16] <= io_wr_data[31:16];
        end
        reg_pre_lo: cmd_pre[31:0]  <= io_wr_data;
        reg_pre_hi: cmd_pre[63:32] <= io_wr_data;
        reg_slot:   cmd_slot <= io_wr_data[7:0];
        reg_ip:     ip_reg   <= io_wr_data;
        default: ;
      endcase
    end
  end

  always_comb begin
    rd_mux = '0;
    case (io_addr)
      reg_ctrl:     rd_mux[1:0] = {res_head.hit, res_valid};
      reg_len:      rd_mux[len_width-1:0] = cmd_len;
      reg_addr:     rd_mux[pmem_addr_width-1:0] = cmd_addr;
      reg_port:     rd_mux = cmd_port;
      reg_pre_lo:   rd_mux = res_head.state[31:0];
      reg_pre_hi:   rd_mux = res_head.state[63:32];
      reg_slot:     rd_mux[8:0] = {slot_valid, slot_head};
      reg_rule:     rd_mux[rule_id_width-1:0] = res_head.rule_id;
      reg_ip:       rd_mux = ip_reg;
      reg_ip_stat:  rd_mux[0] = ip_hit;
      reg_dma_stat: begin
        rd_mux[0]  = !desc_valid && desc_ready;
        rd_mux[8]  = dma_done;
        rd_mux[16] = dma_err;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (stall) begin
      io_rd_data <= {31'd0, ip_hit};
    end else if (rd) begin
      io_rd_data <= rd_mux;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      io_rd_valid <= 1'b0;
      stall       <= 1'b0;
      ip_valid_q  <= 1'b0;
      dma_done    <= 1'b0;
      dma_err     <= 1'b0;
    end else begin
      ip_valid_q  <= wr && (io_addr == reg_ip);
      io_rd_valid <= (rd && !stall && !stall_start) || (stall && ip_done);
      stall       <= stall ? !ip_done : stall_start;
      dma_done    <= (dma_done && !start_wr) || (beat_valid && beat_ready && beat_last);
      if (start_wr && !desc_in_ready) dma_err <= 1'b1;
    end
  end

  assign desc_in = '{addr: cmd_addr, len: cmd_len};

  simple_fifo #(.payload_t(desc_t)) desc_fifo (
    .clk(clk), .rst(rst),
    .din_valid(start_wr), .din(desc_in), .din_ready(desc_in_ready),
    .dout_valid(desc_valid), .dout(desc_head), .dout_ready(desc_ready)
  );

  simple_fifo #(.payload_t(logic [63:0])) pre_fifo (
    .clk(clk), .rst(rst),
    .din_valid(start_wr), .din(cmd_pre), .din_ready(),
    .dout_valid(pre_valid), .dout(pre_head), .dout_ready(pre_ready)
  );

  simple_fifo #(.payload_t(logic [7:0])) slot_fifo (
    .clk(clk), .rst(rst),
    .din_valid(start_wr), .din(cmd_slot), .din_ready(),
    .dout_valid(slot_valid), .dout(slot_head), .dout_ready(release_wr)
  );

  simple_fifo #(.payload_t(result_t)) res_fifo (
    .clk(clk), .rst(rst),
    .din_valid(res_in_valid), .din(res_in), .din_ready(res_in_ready),
    .dout_valid(res_valid), .dout(res_head), .dout_ready(release_wr)
  );

  accel_rd_dma dma_i (
    .clk(clk), .rst(rst),
    .desc(desc_head), .desc_valid(desc_valid), .desc_ready(desc_ready),
    .mem_rd_en(mem_rd_en), .mem_rd_addr(mem_rd_addr), .mem_rd_data(mem_rd_data),
    .beat_data(beat_data), .beat_bytes(beat_bytes), .beat_last(beat_last),
    .beat_valid(beat_valid), .beat_ready(beat_ready)
  );

  pattern_matcher matcher_i (
    .clk(clk), .rst(rst),
    .rule_wr_en(rule_wr_en), .rule_wr_addr(rule_wr_addr), .rule_wr_data(rule_wr_data),
    .pre_state(pre_head), .pre_valid(pre_valid), .pre_ready(pre_ready),
    .beat_data(beat_data), .beat_bytes(beat_bytes), .beat_last(beat_last),
    .beat_valid(beat_valid), .beat_ready(beat_ready),
    .res(res_in), .res_valid(res_in_valid), .res_ready(res_in_ready)
  );

  // Host writes the address little endian, the blocklist holds network order
  ip_match ip_match_i (
    .clk(clk), .rst(rst),
    .addr({ip_reg[7:0], ip_reg[15:8], ip_reg[23:16], ip_reg[31:24]}),
    .valid(ip_valid_q), .match(ip_hit), .done(ip_done)
  );

endmodule

//--- logic/ip_match.sv
`timescale 1ns/1ps

module ip_match import accel_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] addr,
  input  logic        valid,
  output logic        match,
  output logic        done
);

  logic [7:0] eq_vec;
  logic       stage1_valid;

  // Stage one compares against every entry
  always_ff @(posedge clk) begin
    if (valid) begin
      for (int k = 0; k < 8; k++) begin
        eq_vec[k] <= (addr == blocklist[k]);
      end
    end
  end

  // Stage two reduces; results stay until the next lookup
  always_ff @(posedge clk) begin
    if (rst) begin
      stage1_valid <= 1'b0;
      match        <= 1'b0;
      done         <= 1'b0;
    end else begin
      stage1_valid <= valid;
      if (valid) begin
        match <= 1'b0;
        done  <= 1'b0;
      end else if (stage1_valid) begin
        match <= |eq_vec;
        done  <= 1'b1;
      end
    end
  end

endmodule

//--- logic/pattern_matcher.sv
`timescale 1ns/1ps

module pattern_matcher import accel_pkg::*; (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       rule_wr_en,
  input  logic [rule_addr_width-1:0] rule_wr_addr,
  input  logic [rule_id_width-1:0]   rule_wr_data,
  input  logic [63:0]                pre_state,
  input  logic                       pre_valid,
  output logic                       pre_ready,
  input  logic [31:0]                beat_data,
  input  logic [2:0]                 beat_bytes,
  input  logic                       beat_last,
  input  logic                       beat_valid,
  output logic                       beat_ready,
  output result_t                    res,
  output logic                       res_valid,
  input  logic                       res_ready
);

  logic [rule_id_width-1:0] rule_table [2**rule_addr_width];

  logic                     active;
  logic [63:0]              state_q;
  logic                     hit_q;
  logic [rule_id_width-1:0] id_q;
  logic [63:0]              next_state;
  logic                     next_hit;
  logic [rule_id_width-1:0] next_id;

  always_ff @(posedge clk) begin
    if (rule_wr_en) rule_table[rule_wr_addr] <= rule_wr_data;
  end

  assign pre_ready  = !active;
  // Stalls while the result FIFO is full
  assign beat_ready = active && res_ready;

  // Bytes in packet order, LSB first; first nonzero rule ID wins
  always_comb begin
    next_state = state_q;
    next_hit   = hit_q;
    next_id    = id_q;
    for (int i = 0; i < 4; i++) begin
      if (i < beat_bytes) begin
        next_state = {next_state[55:0], beat_data[8*i +: 8]};
        if (!next_hit && rule_table[beat_data[8*i +: 8]] != '0) begin
          next_hit = 1'b1;
          next_id  = rule_table[beat_data[8*i +: 8]];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      active    <= 1'b0;
      res_valid <= 1'b0;
    end else begin
      if (res_valid && res_ready) res_valid <= 1'b0;
      if (pre_valid && pre_ready) begin
        active  <= 1'b1;
        state_q <= pre_state;
        hit_q   <= 1'b0;
        id_q    <= '0;
      end
      if (beat_valid && beat_ready) begin
        state_q <= next_state;
        hit_q   <= next_hit;
        id_q    <= next_id;
        if (beat_last) begin
          active    <= 1'b0;
          res       <= '{hit: next_hit, rule_id: next_id, state: next_state};
          res_valid <= 1'b1;
        end
      end
    end
  end

endmodule

//--- logic/accel_rd_dma.sv
`timescale 1ns/1ps

module accel_rd_dma import accel_pkg::*; (
  input  logic                       clk,
  input  logic                       rst,
  input  desc_t                      desc,
  input  logic                       desc_valid,
  output logic                       desc_ready,
  output logic                       mem_rd_en,
  output logic [pmem_addr_width-1:0] mem_rd_addr,
  input  logic [31:0]                mem_rd_data,
  output logic [31:0]                beat_data,
  output logic [2:0]                 beat_bytes,
  output logic                       beat_last,
  output logic                       beat_valid,
  input  logic                       beat_ready
);

  logic                       busy;
  logic [len_width-1:0]       rem;
  logic [pmem_addr_width-1:0] addr_q;
  logic                       issue;
  logic [2:0]                 issue_bytes;
  logic                       pend_valid;
  logic [2:0]                 pend_bytes;
  logic                       pend_last;
  logic                       skid_valid;
  logic [31:0]                skid_data;
  logic [2:0]                 skid_bytes;
  logic                       skid_last;

  assign desc_ready  = !busy;
  assign issue_bytes = (rem >= 4) ? 3'd4 : rem[2:0];

  // No new read while the skid slot is taken or about to be
  assign issue = busy && (rem != 0) && !skid_valid && !(pend_valid && !beat_ready);

  assign mem_rd_en   = issue;
  assign mem_rd_addr = addr_q;

  // Skid beat goes out first, otherwise the word coming back from memory
  assign beat_valid = skid_valid || pend_valid;
  assign beat_data  = skid_valid ? skid_data : mem_rd_data;
  assign beat_bytes = skid_valid ? skid_bytes : pend_bytes;
  assign beat_last  = skid_valid ? skid_last : pend_last;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy       <= 1'b0;
      rem        <= '0;
      pend_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else begin
      pend_valid <= issue;
      if (desc_valid && desc_ready) begin
        busy   <= 1'b1;
        rem    <= desc.len;
        addr_q <= desc.addr;
      end else if (issue) begin
        rem    <= rem - {7'd0, issue_bytes};
        addr_q <= addr_q + 1'b1;
      end
      if (issue) begin
        pend_bytes <= issue_bytes;
        pend_last  <= (rem <= 4);
      end
      if (skid_valid && beat_ready) begin
        skid_valid <= 1'b0;
      end else if (pend_valid && !beat_ready && !skid_valid) begin
        skid_valid <= 1'b1;
        skid_data  <= mem_rd_data;
        skid_bytes <= pend_bytes;
        skid_last  <= pend_last;
      end
      if (beat_valid && beat_ready && beat_last) busy <= 1'b0;
    end
  end

endmodule

//--- logic/simple_fifo.sv
`timescale 1ns/1ps

module simple_fifo import accel_pkg::*; #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     din_valid,
  input  payload_t din,
  output logic     din_ready,
  output logic     dout_valid,
  output payload_t dout,
  input  logic     dout_ready
);

  localparam int ptr_width = $clog2(slot_count);

  payload_t               mem [slot_count];
  logic [ptr_width-1:0]   wr_ptr;
  logic [ptr_width-1:0]   rd_ptr;
  logic [ptr_width:0]     count;
  logic                   push;
  logic                   pop;

  assign din_ready  = (count != slot_count);
  assign dout_valid = (count != 0);
  assign dout       = mem[rd_ptr];

  // A push into a full FIFO is simply lost
  assign push = din_valid && din_ready;
  assign pop  = dout_valid && dout_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      count <= count + (push ? 1'b1 : 1'b0) - (pop ? 1'b1 : 1'b0);
    end
  end

endmodule

//--- logic/accel_pkg.sv
package accel_pkg;

  localparam int io_addr_width   = 7;
  localparam int io_data_width   = 32;
  localparam int pmem_addr_width = 8;
  localparam int len_width       = 10;
  localparam int slot_count      = 16;
  localparam int rule_addr_width = 8;
  localparam int rule_id_width   = 8;

  // Blocked source addresses, network byte order
  localparam logic [31:0] blocklist [8] = '{
    32'hc0a80001, 32'h0a000005, 32'hac100a14, 32'h08080808,
    32'hcb007101, 32'h7f000001, 32'hc6336407, 32'h2d4f0c21
  };

  // Register byte offsets
  localparam logic [io_addr_width-1:0] reg_ctrl     = 7'h00;
  localparam logic [io_addr_width-1:0] reg_len      = 7'h04;
  localparam logic [io_addr_width-1:0] reg_addr     = 7'h08;
  localparam logic [io_addr_width-1:0] reg_port     = 7'h0c;
  localparam logic [io_addr_width-1:0] reg_pre_lo   = 7'h10;
  localparam logic [io_addr_width-1:0] reg_pre_hi   = 7'h14;
  localparam logic [io_addr_width-1:0] reg_slot     = 7'h18;
  localparam logic [io_addr_width-1:0] reg_rule     = 7'h1c;
  localparam logic [io_addr_width-1:0] reg_ip       = 7'h40;
  localparam logic [io_addr_width-1:0] reg_ip_stat  = 7'h60;
  localparam logic [io_addr_width-1:0] reg_dma_stat = 7'h70;

  typedef struct packed {
    logic [pmem_addr_width-1:0] addr;
    logic [len_width-1:0]       len;
  } desc_t;

  typedef struct packed {
    logic                     hit;
    logic [rule_id_width-1:0] rule_id;
    logic [63:0]              state;
  } result_t;

endpackage
